// File: verilog/supervisor_params.svh
`ifndef SUPERVISOR_PARAMS_SVH
`define SUPERVISOR_PARAMS_SVH

//////////////////////////////
// reset hold
//////////////////////////////

// control_clock cycles a reset line stays held
`define SUPERVISOR_RESET_HOLD 32000000

//////////////////////////////
// status led
//////////////////////////////

// glow ramp period bits
`define SUPERVISOR_SLOW_GLOW_BIT 26
`define SUPERVISOR_FAST_GLOW_BIT 22

// blink gate for force-generate
`define SUPERVISOR_BLINK_BIT 24

// event counter width
`define SUPERVISOR_COUNT_WIDTH 32

`endif

// File: verilog/pin_mode_pkg.sv
package pin_mode_pkg;

    // function of the shared status pin
    typedef enum logic [1:0] {
        // status led with glow and blink
        mode_led        = 2'd0,
        // copy of the drive reset line
        mode_follow_opt = 2'd1,
        // copy of the console reset line
        mode_follow_dc  = 2'd2,
        // pin left floating
        mode_release    = 2'd3
    } pin_mode_t;

endpackage

// File: verilog/health_pkg.sv
`include "supervisor_params.svh"

package health_pkg;

    //////////////////////////////
    // health counters
    //////////////////////////////

    // wraps around, never saturates
    typedef logic [`SUPERVISOR_COUNT_WIDTH-1:0] event_count_t;

endpackage

// File: verilog/async_event_counter.sv
`timescale 1ns/1ps

module async_event_counter #(
    parameter bit COUNT_FALLING = 1'b0
) (
    input  logic                     control_clock,
    input  logic                     reset_dc,
    input  logic                     async_level,
    output logic                     synced_level,
    output health_pkg::event_count_t event_count
);

    logic sync_meta;
    logic prev_level;
    logic edge_seen;

    // falling edge for lock loss, rising otherwise
    assign edge_seen = COUNT_FALLING ? (prev_level & ~synced_level)
                                     : (~prev_level & synced_level);

    //////////////////////////////
    // two-flop synchronizer
    //////////////////////////////

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            sync_meta    <= 1'b0;
            synced_level <= 1'b0;
        end else begin
            sync_meta    <= async_level;
            synced_level <= sync_meta;
        end
    end

    //////////////////////////////
    // edge register and count
    //////////////////////////////

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            prev_level  <= 1'b0;
            event_count <= '0;
        end else begin
            prev_level <= synced_level;
            if (edge_seen) begin
                event_count <= event_count + health_pkg::event_count_t'(1);
            end
        end
    end

endmodule

// File: verilog/reset_stretcher.sv
`timescale 1ns/1ps

`include "supervisor_params.svh"

module reset_stretcher #(
    parameter int HOLD_CYCLES        = `SUPERVISOR_RESET_HOLD,
    parameter bit ACTIVE_AFTER_RESET = 1'b1
) (
    input  logic control_clock,
    input  logic reset_dc,
    input  logic request,
    output logic reset_active
);

    localparam int COUNT_WIDTH = $clog2(HOLD_CYCLES + 1);
    localparam logic [COUNT_WIDTH-1:0] HOLD_LOAD = COUNT_WIDTH'(HOLD_CYCLES);

    logic [COUNT_WIDTH-1:0] hold_count;

    // line is held while cycles remain
    assign reset_active = (hold_count != '0);

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            hold_count <= ACTIVE_AFTER_RESET ? HOLD_LOAD : '0;
        end else if (request) begin
            // restarts a running hold as well
            hold_count <= HOLD_LOAD;
        end else if (hold_count != '0) begin
            hold_count <= hold_count - COUNT_WIDTH'(1);
        end
    end

endmodule

// File: verilog/led_glow.sv
`timescale 1ns/1ps

`include "supervisor_params.svh"

module led_glow #(
    parameter int GLOW_BIT = `SUPERVISOR_SLOW_GLOW_BIT
) (
    input  logic control_clock,
    input  logic reset_dc,
    output logic glow
);

    logic [GLOW_BIT:0] glow_count;
    logic [3:0]        brightness;

    //////////////////////////////
    // triangle ramp
    //////////////////////////////

    // second half of the period ramps back down
    assign brightness = glow_count[GLOW_BIT] ? ~glow_count[GLOW_BIT-1 -: 4]
                                             : glow_count[GLOW_BIT-1 -: 4];

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            glow_count <= '0;
        end else begin
            glow_count <= glow_count + (GLOW_BIT + 1)'(1);
        end
    end

    // pwm against the low nibble
    assign glow = (glow_count[3:0] < brightness);

endmodule

// File: verilog/status_pin_mux.sv
`timescale 1ns/1ps

`include "supervisor_params.svh"

module status_pin_mux #(
    parameter int BLINK_BIT = `SUPERVISOR_BLINK_BIT
) (
    input  logic                    control_clock,
    input  logic                    reset_dc,
    input  pin_mode_pkg::pin_mode_t mode,
    input  logic                    hdmi_pll_ready,
    input  logic                    resync_active,
    input  logic                    generate_active,
    input  logic                    output_ready,
    input  logic                    dc_reset_active,
    input  logic                    opt_reset_active,
    input  logic                    slow_glow,
    input  logic                    fast_glow,
    output logic                    pin_drive,
    output logic                    pin_level
);

    logic [BLINK_BIT:0] blink_count;
    logic               led_level;

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            blink_count <= '0;
        end else begin
            blink_count <= blink_count + (BLINK_BIT + 1)'(1);
        end
    end

    //////////////////////////////
    // led priorities
    //////////////////////////////

    // led is active low, so high means dark
    always_comb begin
        if (!hdmi_pll_ready) begin
            led_level = 1'b1;
        end else if (resync_active) begin
            led_level = ~fast_glow;
        end else if (generate_active) begin
            led_level = blink_count[BLINK_BIT] ? ~fast_glow : 1'b1;
        end else if (output_ready) begin
            led_level = 1'b0;
        end else begin
            led_level = ~slow_glow;
        end
    end

    //////////////////////////////
    // pin register
    //////////////////////////////

    always_ff @(posedge control_clock) begin
        if (reset_dc) begin
            pin_drive <= 1'b0;
            pin_level <= 1'b0;
        end else begin
            case (mode)
                pin_mode_pkg::mode_led: begin
                    pin_drive <= 1'b1;
                    pin_level <= led_level;
                end
                // open drain copy of a reset line
                pin_mode_pkg::mode_follow_opt: begin
                    pin_drive <= opt_reset_active;
                    pin_level <= 1'b0;
                end
                pin_mode_pkg::mode_follow_dc: begin
                    pin_drive <= dc_reset_active;
                    pin_level <= 1'b0;
                end
                pin_mode_pkg::mode_release: begin
                    pin_drive <= 1'b0;
                    pin_level <= 1'b0;
                end
            endcase
        end
    end

endmodule

// File: verilog/board_supervisor.sv
`timescale 1ns/1ps

`include "supervisor_params.svh"

module board_supervisor #(
    parameter int HOLD_CYCLES   = `SUPERVISOR_RESET_HOLD,
    parameter int SLOW_GLOW_BIT = `SUPERVISOR_SLOW_GLOW_BIT,
    parameter int FAST_GLOW_BIT = `SUPERVISOR_FAST_GLOW_BIT,
    parameter int BLINK_BIT     = `SUPERVISOR_BLINK_BIT
) (
    input  logic                     control_clock,
    input  logic                     reset_dc,
    input  logic                     pll54_locked,
    input  logic                     hdmi_pll_locked,
    input  logic                     video_resync,
    input  logic                     force_generate,
    input  logic                     output_ready,
    input  logic                     opt_reset_request,
    input  pin_mode_pkg::pin_mode_t  reset_conf,
    output logic                     dc_reset_active,
    output logic                     opt_reset_active,
    output logic                     status_pin_drive,
    output logic                     status_pin_level,
    output health_pkg::event_count_t pll54_lockloss_count,
    output health_pkg::event_count_t hdmi_lockloss_count,
    output health_pkg::event_count_t resync_count
);

    logic hdmi_pll_ready;
    logic resync_active;
    logic generate_active;
    logic slow_glow;
    logic fast_glow;

    //////////////////////////////
    // health monitors
    //////////////////////////////

    async_event_counter #(.COUNT_FALLING(1'b1)) pll54_monitor (
        .control_clock(control_clock),
        .reset_dc     (reset_dc),
        .async_level  (pll54_locked),
        .synced_level (),
        .event_count  (pll54_lockloss_count)
    );

    async_event_counter #(.COUNT_FALLING(1'b1)) hdmi_pll_monitor (
        .control_clock(control_clock),
        .reset_dc     (reset_dc),
        .async_level  (hdmi_pll_locked),
        .synced_level (hdmi_pll_ready),
        .event_count  (hdmi_lockloss_count)
    );

    async_event_counter #(.COUNT_FALLING(1'b0)) resync_monitor (
        .control_clock(control_clock),
        .reset_dc     (reset_dc),
        .async_level  (video_resync),
        .synced_level (resync_active),
        .event_count  (resync_count)
    );

    // only the level is needed here
    async_event_counter #(.COUNT_FALLING(1'b0)) force_generate_monitor (
        .control_clock(control_clock),
        .reset_dc     (reset_dc),
        .async_level  (force_generate),
        .synced_level (generate_active),
        .event_count  ()
    );

    //////////////////////////////
    // reset lines
    //////////////////////////////

    // console held from reset onwards
    reset_stretcher #(
        .HOLD_CYCLES       (HOLD_CYCLES),
        .ACTIVE_AFTER_RESET(1'b1)
    ) dc_reset_hold (
        .control_clock(control_clock),
        .reset_dc     (reset_dc),
        .request      (1'b0),
        .reset_active (dc_reset_active)
    );

    reset_stretcher #(
        .HOLD_CYCLES       (HOLD_CYCLES),
        .ACTIVE_AFTER_RESET(1'b0)
    ) opt_reset_hold (
        .control_clock(control_clock),
        .reset_dc     (reset_dc),
        .request      (opt_reset_request),
        .reset_active (opt_reset_active)
    );

    //////////////////////////////
    // status pin
    //////////////////////////////

    led_glow #(.GLOW_BIT(SLOW_GLOW_BIT)) slow_glow_gen (
        .control_clock(control_clock),
        .reset_dc     (reset_dc),
        .glow         (slow_glow)
    );

    led_glow #(.GLOW_BIT(FAST_GLOW_BIT)) fast_glow_gen (
        .control_clock(control_clock),
        .reset_dc     (reset_dc),
        .glow         (fast_glow)
    );

    status_pin_mux #(.BLINK_BIT(BLINK_BIT)) status_pin_mux_inst (
        .control_clock   (control_clock),
        .reset_dc        (reset_dc),
        .mode            (reset_conf),
        .hdmi_pll_ready  (hdmi_pll_ready),
        .resync_active   (resync_active),
        .generate_active (generate_active),
        .output_ready    (output_ready),
        .dc_reset_active (dc_reset_active),
        .opt_reset_active(opt_reset_active),
        .slow_glow       (slow_glow),
        .fast_glow       (fast_glow),
        .pin_drive       (status_pin_drive),
        .pin_level       (status_pin_level)
    );

endmodule

// File: test/tb_board_supervisor.sv
`timescale 1ns/1ps

module tb_board_supervisor;

    localparam int HOLD = 20;
    // test sum is under 2,000 cycles
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int PULSE_PLL54 = 0;
    localparam int PULSE_HDMI = 1;
    localparam int PULSE_RESYNC = 2;

    logic                    control_clock;
    logic                    reset_dc;
    logic                    pll54_locked;
    logic                    hdmi_pll_locked;
    logic                    video_resync;
    logic                    force_generate;
    logic                    output_ready;
    logic                    opt_reset_request;
    pin_mode_pkg::pin_mode_t reset_conf;
    logic                    dc_reset_active;
    logic                    opt_reset_active;
    logic                    status_pin_drive;
    logic                    status_pin_level;
    logic [31:0]             pll54_lockloss_count;
    logic [31:0]             hdmi_lockloss_count;
    logic [31:0]             resync_count;

    logic [15:0] lfsr_state;
    logic [31:0] expected_pll54;
    logic [31:0] expected_hdmi;
    logic [31:0] expected_resync;
    int          cycle_count = 0;

    board_supervisor #(
        .HOLD_CYCLES  (HOLD),
        .SLOW_GLOW_BIT(7),
        .FAST_GLOW_BIT(5),
        .BLINK_BIT    (6)
    ) board_supervisor_inst (
        .control_clock       (control_clock),
        .reset_dc            (reset_dc),
        .pll54_locked        (pll54_locked),
        .hdmi_pll_locked     (hdmi_pll_locked),
        .video_resync        (video_resync),
        .force_generate      (force_generate),
        .output_ready        (output_ready),
        .opt_reset_request   (opt_reset_request),
        .reset_conf          (reset_conf),
        .dc_reset_active     (dc_reset_active),
        .opt_reset_active    (opt_reset_active),
        .status_pin_drive    (status_pin_drive),
        .status_pin_level    (status_pin_level),
        .pll54_lockloss_count(pll54_lockloss_count),
        .hdmi_lockloss_count (hdmi_lockloss_count),
        .resync_count        (resync_count)
    );

    initial begin
        control_clock = 1'b0;
        forever #4 control_clock = ~control_clock;
    end

    always @(posedge control_clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_with_failure();
        end
    end

    //////////////////////////////
    // checking
    //////////////////////////////

    task automatic stop_with_failure();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic expect_bit(input string test_name, input string what,
                              input logic expected, input logic actual);
        assert (actual === expected) else begin
            $display("FAIL %s: %s expected %0b, actual %0b", test_name, what, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic expect_count(input string test_name, input string what,
                                input logic [31:0] expected, input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("FAIL %s: %s expected %0d, actual %0d", test_name, what, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic require_true(input string test_name, input logic condition,
                                input string description);
        assert (condition) else begin
            $display("%s: %s", test_name, description);
            stop_with_failure();
        end
    endtask

    task automatic expect_all_counts(input string test_name);
        expect_count(test_name, "pll54_lockloss_count", expected_pll54, pll54_lockloss_count);
        expect_count(test_name, "hdmi_lockloss_count", expected_hdmi, hdmi_lockloss_count);
        expect_count(test_name, "resync_count", expected_resync, resync_count);
    endtask

    //////////////////////////////
    // stimulus helpers
    //////////////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] advance_lfsr(input logic [15:0] state);
        advance_lfsr = state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
    endfunction

    task automatic take_random_bits(input int bit_count, output int value);
        value = 0;
        for (int b = 0; b < bit_count; b++) begin
            value = (value << 1) | {31'd0, lfsr_state[0]};
            lfsr_state = advance_lfsr(lfsr_state);
        end
    endtask

    // 1 to 7 events
    task automatic pick_event_count(output int count);
        int raw;
        take_random_bits(3, raw);
        count = (raw % 7) + 1;
    endtask

    // 3 to 6 cycles
    task automatic pick_pulse_width(output int width);
        int raw;
        take_random_bits(2, raw);
        width = raw + 3;
    endtask

    task automatic pulse_input(input int which);
        int active_cycles;
        int idle_cycles;
        pick_pulse_width(active_cycles);
        pick_pulse_width(idle_cycles);
        case (which)
            PULSE_PLL54: pll54_locked = 1'b0;
            PULSE_HDMI:  hdmi_pll_locked = 1'b0;
            default:     video_resync = 1'b1;
        endcase
        repeat (active_cycles) @(negedge control_clock);
        case (which)
            PULSE_PLL54: pll54_locked = 1'b1;
            PULSE_HDMI:  hdmi_pll_locked = 1'b1;
            default:     video_resync = 1'b0;
        endcase
        repeat (idle_cycles) @(negedge control_clock);
    endtask

    task automatic watch_pin_levels(input string test_name, input int max_cycles,
                                    output logic seen_both);
        logic seen_high;
        logic seen_low;
        int   waited;
        seen_high = 1'b0;
        seen_low = 1'b0;
        waited = 0;
        while (!(seen_high && seen_low) && waited < max_cycles) begin
            expect_bit(test_name, "status_pin_drive", 1'b1, status_pin_drive);
            if (status_pin_level) begin
                seen_high = 1'b1;
            end else begin
                seen_low = 1'b1;
            end
            waited++;
            @(negedge control_clock);
        end
        seen_both = seen_high && seen_low;
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////

    task automatic verify_console_reset();
        expect_bit("console_reset", "dc_reset_active in reset", 1'b1, dc_reset_active);
        reset_dc = 1'b0;
        for (int i = 0; i < HOLD; i++) begin
            expect_bit("console_reset", "dc_reset_active held", 1'b1, dc_reset_active);
            @(negedge control_clock);
        end
        for (int i = 0; i < 10; i++) begin
            expect_bit("console_reset", "dc_reset_active released", 1'b0, dc_reset_active);
            @(negedge control_clock);
        end
        expect_bit("console_reset", "opt_reset_active", 1'b0, opt_reset_active);
        expect_all_counts("console_reset");
    endtask

    task automatic request_drive_reset();
        reset_conf = pin_mode_pkg::mode_follow_opt;
        repeat (3) @(negedge control_clock);
        expect_bit("drive_reset", "status_pin_drive idle", 1'b0, status_pin_drive);
        opt_reset_request = 1'b1;
        @(negedge control_clock);
        opt_reset_request = 1'b0;
        for (int i = 0; i < HOLD; i++) begin
            expect_bit("drive_reset", "opt_reset_active", 1'b1, opt_reset_active);
            expect_bit("drive_reset", "status_pin_drive", (i >= 1), status_pin_drive);
            expect_bit("drive_reset", "status_pin_level", 1'b0, status_pin_level);
            @(negedge control_clock);
        end
        expect_bit("drive_reset", "opt_reset_active after hold", 1'b0, opt_reset_active);
        expect_bit("drive_reset", "status_pin_drive lag", 1'b1, status_pin_drive);
        @(negedge control_clock);
        expect_bit("drive_reset", "status_pin_drive released", 1'b0, status_pin_drive);
    endtask

    task automatic count_lock_losses();
        int pll54_drops;
        int hdmi_drops;
        pick_event_count(pll54_drops);
        pick_event_count(hdmi_drops);
        if (hdmi_drops == pll54_drops) begin
            hdmi_drops = (pll54_drops % 7) + 1;
        end
        for (int i = 0; i < pll54_drops; i++) begin
            pulse_input(PULSE_PLL54);
        end
        for (int i = 0; i < hdmi_drops; i++) begin
            pulse_input(PULSE_HDMI);
        end
        expected_pll54 = expected_pll54 + 32'(pll54_drops);
        expected_hdmi = expected_hdmi + 32'(hdmi_drops);
        repeat (5) @(negedge control_clock);
        expect_all_counts("lock_loss");
    endtask

    task automatic count_resyncs();
        int resyncs;
        pick_event_count(resyncs);
        for (int i = 0; i < resyncs; i++) begin
            pulse_input(PULSE_RESYNC);
        end
        expected_resync = expected_resync + 32'(resyncs);
        repeat (5) @(negedge control_clock);
        expect_all_counts("resync");
    endtask

    task automatic led_mode_priorities();
        logic seen_both;
        reset_conf = pin_mode_pkg::mode_led;
        // missing pll outranks output ready
        output_ready = 1'b1;
        hdmi_pll_locked = 1'b0;
        expected_hdmi = expected_hdmi + 32'd1;
        repeat (5) @(negedge control_clock);
        expect_bit("led_mode", "status_pin_drive no pll", 1'b1, status_pin_drive);
        expect_bit("led_mode", "status_pin_level no pll", 1'b1, status_pin_level);
        hdmi_pll_locked = 1'b1;
        repeat (5) @(negedge control_clock);
        expect_bit("led_mode", "status_pin_drive ready", 1'b1, status_pin_drive);
        expect_bit("led_mode", "status_pin_level ready", 1'b0, status_pin_level);
        output_ready = 1'b0;
        repeat (2) @(negedge control_clock);
        watch_pin_levels("led_mode", 512, seen_both);
        require_true("led_mode", seen_both, "slow glow did not show both pin levels");
        // resync outranks output ready
        output_ready = 1'b1;
        video_resync = 1'b1;
        expected_resync = expected_resync + 32'd1;
        repeat (4) @(negedge control_clock);
        watch_pin_levels("led_mode", 128, seen_both);
        require_true("led_mode", seen_both, "fast glow did not show both pin levels");
        video_resync = 1'b0;
        // generate blinks the fast glow over output ready
        force_generate = 1'b1;
        repeat (4) @(negedge control_clock);
        watch_pin_levels("led_mode", 128, seen_both);
        require_true("led_mode", seen_both, "generate blink did not show both pin levels");
        force_generate = 1'b0;
        output_ready = 1'b0;
        repeat (5) @(negedge control_clock);
        expect_all_counts("led_mode");
    endtask

    task automatic follow_dc_and_release();
        reset_conf = pin_mode_pkg::mode_follow_dc;
        reset_dc = 1'b1;
        repeat (4) @(negedge control_clock);
        reset_dc = 1'b0;
        expected_pll54 = 32'd0;
        expected_hdmi = 32'd0;
        expected_resync = 32'd0;
        for (int i = 0; i < HOLD + 2; i++) begin
            expect_bit("follow_dc", "dc_reset_active", (i < HOLD), dc_reset_active);
            expect_bit("follow_dc", "status_pin_drive", (i >= 1) && (i <= HOLD),
                       status_pin_drive);
            @(negedge control_clock);
        end
        expect_all_counts("follow_dc");
        reset_conf = pin_mode_pkg::mode_release;
        @(negedge control_clock);
        for (int i = 0; i < 30; i++) begin
            opt_reset_request = (i == 2);
            expect_bit("release", "status_pin_drive", 1'b0, status_pin_drive);
            @(negedge control_clock);
        end
    endtask

    initial begin
        reset_dc = 1'b1;
        pll54_locked = 1'b1;
        hdmi_pll_locked = 1'b1;
        video_resync = 1'b0;
        force_generate = 1'b0;
        output_ready = 1'b0;
        opt_reset_request = 1'b0;
        reset_conf = pin_mode_pkg::mode_led;
        lfsr_state = 16'd31;
        expected_pll54 = 32'd0;
        expected_hdmi = 32'd0;
        expected_resync = 32'd0;
        repeat (16) @(negedge control_clock);
        verify_console_reset();
        request_drive_reset();
        count_lock_losses();
        count_resyncs();
        led_mode_priorities();
        follow_dc_and_release();
        $display("Finished with no errors");
        $finish;
    end

endmodule

// File: board_supervisor.f
+incdir+verilog
verilog/pin_mode_pkg.sv
verilog/health_pkg.sv
verilog/async_event_counter.sv
verilog/reset_stretcher.sv
verilog/led_glow.sv
verilog/status_pin_mux.sv
verilog/board_supervisor.sv
test/tb_board_supervisor.sv

// File: Makefile
.PHONY: all lint clean

# build and run, pass only when the log holds the pass message
all:
	verilator --binary --assert -j 0 -f board_supervisor.f --top-module tb_board_supervisor
	-./obj_dir/Vtb_board_supervisor > sim.log 2>&1
	cat sim.log
	grep -q "Finished with no errors" sim.log

lint:
	verilator --lint-only --timing -f board_supervisor.f --top-module board_supervisor

clean:
	rm -rf obj_dir sim.log
